/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_shift_unit
FILELIST := build.f

OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) testbench/tb_shift_model.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+testbench
rtl/shift_pkg.sv
rtl/shift_core.sv
rtl/cond_eval.sv
rtl/flag_gen.sv
rtl/result_fifo.sv
rtl/shift_ctrl.sv
rtl/shift_unit.sv
testbench/tb_shift_unit.sv

/* rtl/cond_eval.sv */
////////////////////////////////////////////////////////////////////////////
// condition evaluator
// checks a 4-bit condition code against the incoming flag word
////////////////////////////////////////////////////////////////////////////

module cond_eval (
  input  shift_pkg::flags_t flags,
  input  shift_pkg::cond_t  cond,
  output logic              taken
);

  logic c_f;
  logic o_f;
  logic s_f;
  logic z_f;
  logic p_f;

  always_comb begin
    c_f = flags[shift_pkg::flag_c];
    o_f = flags[shift_pkg::flag_o];
    s_f = flags[shift_pkg::flag_s];
    z_f = flags[shift_pkg::flag_z];
    p_f = flags[shift_pkg::flag_p];

    case (cond)
      4'd0:    taken = o_f;            // O
      4'd1:    taken = ~o_f;           // NO
      4'd2:    taken = c_f;            // C
      4'd3:    taken = ~c_f;           // NC
      4'd4:    taken = z_f;            // Z
      4'd5:    taken = ~z_f;           // NZ
      4'd6:    taken = s_f;            // S
      4'd7:    taken = ~s_f;           // NS
      4'd8:    taken = p_f;            // P
      4'd9:    taken = ~p_f;           // NP
      4'd10:   taken = c_f | z_f;      // below or equal
      4'd11:   taken = ~(c_f | z_f);   // above
      default: taken = 1'b1;           // 12..15 always
    endcase
  end

endmodule

/* rtl/flag_gen.sv */
////////////////////////////////////////////////////////////////////////////
// flag generation stage
// registers the shifter output and forms C/S/Z/P at the registered size;
// a failed condition passes the truncated operand and old flags instead
////////////////////////////////////////////////////////////////////////////

module flag_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  shift_pkg::op_size_e size,
  input  shift_pkg::data_t    result,
  input  logic                carry,
  input  logic                taken,
  input  shift_pkg::data_t    a,
  input  shift_pkg::flags_t   flags_in,
  input  shift_pkg::tag_t     tag,
  output shift_pkg::data_t    out_data,
  output shift_pkg::flags_t   out_flags,
  output shift_pkg::tag_t     out_tag
);

  shift_pkg::op_size_e size_q;
  logic                taken_q;
  logic                carry_q;
  shift_pkg::data_t    result_q;
  shift_pkg::data_t    a_q;
  shift_pkg::flags_t   flags_q;
  shift_pkg::tag_t     tag_q;
  shift_pkg::flags_t   new_flags;

  // select state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      size_q  <= shift_pkg::sz64;
      taken_q <= 1'b0;
    end else if (load) begin
      size_q  <= size;
      taken_q <= taken;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (load) begin
      carry_q  <= carry;
      result_q <= result;
      a_q      <= a;
      flags_q  <= flags_in;
      tag_q    <= tag;
    end
  end

  always_comb begin
    new_flags                    = '0;             // O and A stay 0
    new_flags[shift_pkg::flag_c] = carry_q;
    new_flags[shift_pkg::flag_o] = 1'b0;
    new_flags[shift_pkg::flag_a] = 1'b0;
    new_flags[shift_pkg::flag_s] = shift_pkg::top_bit(size_q, result_q);
    new_flags[shift_pkg::flag_z] = ~|result_q;      // result already masked to size
    new_flags[shift_pkg::flag_p] = ~^result_q[7:0]; // even parity, low byte
  end

  assign out_data  = taken_q ? result_q : (a_q & shift_pkg::size_mask(size_q));
  assign out_flags = taken_q ? new_flags : flags_q;
  assign out_tag   = tag_q;

endmodule

/* rtl/result_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// result queue
// circular buffer holding finished results in issue order
////////////////////////////////////////////////////////////////////////////

module result_fifo #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  shift_pkg::tag_t   push_tag,
  input  shift_pkg::data_t  push_data,
  input  shift_pkg::flags_t push_flags,
  input  logic              pop,
  output logic              empty,
  output shift_pkg::tag_t   head_tag,
  output shift_pkg::data_t  head_data,
  output shift_pkg::flags_t head_flags
);

  localparam int AW = $clog2(QUEUE_DEPTH);

  shift_pkg::tag_t   tag_mem   [QUEUE_DEPTH];
  shift_pkg::data_t  data_mem  [QUEUE_DEPTH];
  shift_pkg::flags_t flags_mem [QUEUE_DEPTH];

  logic [AW-1:0] wr_ptr;   // wraps on power-of-two depth
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;    // entries held

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr]   <= push_tag;
      data_mem[wr_ptr]  <= push_data;
      flags_mem[wr_ptr] <= push_flags;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // both or neither
      endcase
    end
  end

  assign empty      = (count == '0);
  assign head_tag   = tag_mem[rd_ptr];    // first-word fall-through
  assign head_data  = data_mem[rd_ptr];
  assign head_flags = flags_mem[rd_ptr];

endmodule

/* rtl/shift_core.sv */
////////////////////////////////////////////////////////////////////////////
// shift core
// combinational barrel shifter that truncates the operand and count to the
// op size, shifts left or right with zero or sign fill and returns carry-out
////////////////////////////////////////////////////////////////////////////

module shift_core (
  input  shift_pkg::shift_op_e op,
  input  shift_pkg::op_size_e  size,
  input  shift_pkg::data_t     a,
  input  shift_pkg::count_t    count,
  output shift_pkg::data_t     result,
  output logic                 carry
);

  shift_pkg::data_t  mask;      // live bits at this size
  shift_pkg::data_t  a_trunc;   // operand cut to size
  shift_pkg::data_t  a_ext;     // operand with fill above size
  shift_pkg::count_t cnt;       // count modulo width
  logic              sign;      // operand msb at size
  logic              fill;      // bit shifted in from the top
  logic [64:0]       wide_l;    // bit 'width' catches the last bit out
  logic signed [65:0] wide_r;   // bit 0 catches the last bit out

  always_comb begin
    mask    = shift_pkg::size_mask(size);
    a_trunc = a & mask;
    sign    = shift_pkg::top_bit(size, a_trunc);

    case (size)                                   // count mod operand width
      shift_pkg::sz8:  cnt = {3'b000, count[2:0]};
      shift_pkg::sz16: cnt = {2'b00, count[3:0]};
      shift_pkg::sz32: cnt = {1'b0, count[4:0]};
      default:         cnt = count;
    endcase

    fill  = (op == shift_pkg::sar) & sign;        // zero fill unless sar
    a_ext = a_trunc | (fill ? ~mask : '0);        // replicate sign above size

    wide_l = {1'b0, a_trunc} << cnt;
    wide_r = $signed({fill, a_ext, 1'b0}) >>> cnt;

    if (op == shift_pkg::shl) begin
      result = wide_l[63:0] & mask;
      case (size)                                 // first bit above the size
        shift_pkg::sz8:  carry = wide_l[8];
        shift_pkg::sz16: carry = wide_l[16];
        shift_pkg::sz32: carry = wide_l[32];
        default:         carry = wide_l[64];
      endcase
    end else begin
      result = wide_r[64:1] & mask;               // zero-extend above size
      carry  = wide_r[0];                         // 0 when cnt is 0
    end
  end

endmodule

/* rtl/shift_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// shift cluster control
// pipeline valids, queue push/pop, writeback credit counter and
// issue credit return
////////////////////////////////////////////////////////////////////////////

module shift_ctrl #(
  parameter int OUT_CREDITS = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic out_credit,
  input  logic fifo_empty,
  output logic s1_valid,
  output logic push,
  output logic pop,
  output logic res_valid,
  output logic in_credit
);

  localparam int CW = $clog2(OUT_CREDITS + 1);   // holds 0..OUT_CREDITS

  logic          s2_valid;     // stage-2 holds a finished result
  logic [CW-1:0] credits;      // writeback credits in hand
  logic          have_credit;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline valids
  ////////////////////////////////////////////////////////////////////////////

  assign s1_valid = in_valid;   // load strobe for the flag stage

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;     // flag stage output valid next cycle
    end
  end

  assign push = s2_valid;

  ////////////////////////////////////////////////////////////////////////////
  // writeback credits and pop
  ////////////////////////////////////////////////////////////////////////////

  assign have_credit = (credits != '0);
  assign pop         = ~fifo_empty & have_credit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CW'(OUT_CREDITS);
    end else begin
      case ({out_credit, pop})
        2'b10:   credits <= credits + 1'b1;   // grant only
        2'b01:   credits <= credits - 1'b1;   // spend only
        default: credits <= credits;          // grant and spend cancel
      endcase
    end
  end

  // one result out, one issue credit back
  assign res_valid = pop;
  assign in_credit = pop;

endmodule

/* rtl/shift_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shift cluster package
// shared widths, flag bit positions, op and size encodings, and the
// size helpers used by the datapath blocks
////////////////////////////////////////////////////////////////////////////

package shift_pkg;

  typedef logic [63:0] data_t;   // operand / result
  typedef logic [5:0]  tag_t;    // micro-op tag
  typedef logic [5:0]  flags_t;  // {C, O, A, S, Z, P}
  typedef logic [5:0]  count_t;  // raw shift count
  typedef logic [3:0]  cond_t;   // condition code

  // bit positions inside flags_t
  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

  typedef enum logic [1:0] {
    shl = 2'd0,   // logical left
    shr = 2'd1,   // logical right
    sar = 2'd2    // arithmetic right
  } shift_op_e;

  typedef enum logic [1:0] {
    sz8  = 2'd0,
    sz16 = 2'd1,
    sz32 = 2'd2,
    sz64 = 2'd3
  } op_size_e;

  // ones over the live bits of the operand size
  function automatic data_t size_mask(op_size_e size);
    case (size)
      sz8:     return 64'h0000_0000_0000_00ff;
      sz16:    return 64'h0000_0000_0000_ffff;
      sz32:    return 64'h0000_0000_ffff_ffff;
      default: return 64'hffff_ffff_ffff_ffff;
    endcase
  endfunction

  // msb of value at the given size
  function automatic logic top_bit(op_size_e size, data_t value);
    case (size)
      sz8:     return value[7];
      sz16:    return value[15];
      sz32:    return value[31];
      default: return value[63];
    endcase
  endfunction

endpackage

/* rtl/shift_unit.sv */
////////////////////////////////////////////////////////////////////////////
// shift execution cluster top
// shifter and condition check feed the flag stage, then the in-order
// result queue; credits govern both issue and writeback
////////////////////////////////////////////////////////////////////////////

module shift_unit #(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // issue side
  input  logic                 in_valid,
  input  shift_pkg::shift_op_e in_op,
  input  shift_pkg::op_size_e  in_size,
  input  shift_pkg::data_t     in_a,
  input  shift_pkg::count_t    in_count,
  input  shift_pkg::tag_t      in_tag,
  input  logic                 in_cond_en,
  input  shift_pkg::cond_t     in_cond,
  input  shift_pkg::flags_t    in_flags,
  output logic                 in_credit,
  // writeback side
  output logic                 res_valid,
  output shift_pkg::tag_t      res_tag,
  output shift_pkg::data_t     res_data,
  output shift_pkg::flags_t    res_flags,
  input  logic                 out_credit
);

  shift_pkg::data_t  sh_result;
  logic              sh_carry;
  logic              cond_true;
  logic              s1_valid;
  logic              push;
  logic              pop;
  logic              fifo_empty;
  shift_pkg::data_t  fg_data;
  shift_pkg::flags_t fg_flags;
  shift_pkg::tag_t   fg_tag;

  shift_ctrl #(.OUT_CREDITS(OUT_CREDITS)) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .out_credit (out_credit),
    .fifo_empty (fifo_empty),
    .s1_valid   (s1_valid),
    .push       (push),
    .pop        (pop),
    .res_valid  (res_valid),
    .in_credit  (in_credit)
  );

  shift_core u_core (
    .op     (in_op),
    .size   (in_size),
    .a      (in_a),
    .count  (in_count),
    .result (sh_result),
    .carry  (sh_carry)
  );

  cond_eval u_cond (
    .flags (in_flags),
    .cond  (in_cond),
    .taken (cond_true)
  );

  flag_gen u_flags (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (s1_valid),
    .size      (in_size),
    .result    (sh_result),
    .carry     (sh_carry),
    .taken     (~in_cond_en | cond_true),   // unconditional ops always taken
    .a         (in_a),
    .flags_in  (in_flags),
    .tag       (in_tag),
    .out_data  (fg_data),
    .out_flags (fg_flags),
    .out_tag   (fg_tag)
  );

  result_fifo #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_tag   (fg_tag),
    .push_data  (fg_data),
    .push_flags (fg_flags),
    .pop        (pop),
    .empty      (fifo_empty),
    .head_tag   (res_tag),
    .head_data  (res_data),
    .head_flags (res_flags)
  );

endmodule

/* testbench/tb_shift_model.svh */
////////////////////////////////////////////////////////////////////////////
// shift cluster reference model
// expected result and flag word from the shift rules, plus typed compares
////////////////////////////////////////////////////////////////////////////

`ifndef TB_SHIFT_MODEL_SVH
`define TB_SHIFT_MODEL_SVH

function automatic int size_width(shift_pkg::op_size_e size);
  case (size)
    shift_pkg::sz8:  return 8;
    shift_pkg::sz16: return 16;
    shift_pkg::sz32: return 32;
    default:         return 64;
  endcase
endfunction

// flag word is {C, O, A, S, Z, P}
function automatic logic cond_holds(shift_pkg::flags_t f, shift_pkg::cond_t cond);
  case (cond)
    4'd0:    return f[4];
    4'd1:    return !f[4];
    4'd2:    return f[5];
    4'd3:    return !f[5];
    4'd4:    return f[1];
    4'd5:    return !f[1];
    4'd6:    return f[2];
    4'd7:    return !f[2];
    4'd8:    return f[0];
    4'd9:    return !f[0];
    4'd10:   return f[5] | f[1];
    4'd11:   return !(f[5] | f[1]);
    default: return 1'b1;
  endcase
endfunction

function automatic void model_op(
  input  shift_pkg::shift_op_e op,
  input  shift_pkg::op_size_e  size,
  input  shift_pkg::data_t     a,
  input  shift_pkg::count_t    count,
  input  logic                 cond_en,
  input  shift_pkg::cond_t     cond,
  input  shift_pkg::flags_t    flags_in,
  output shift_pkg::data_t     data,
  output shift_pkg::flags_t    flags
);
  int               w;
  int               n;
  shift_pkg::data_t m;
  shift_pkg::data_t at;
  shift_pkg::data_t res;
  logic             c;
  w  = size_width(size);
  m  = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
  at = a & m;                                             // operand cut to size
  n  = int'(count) % w;
  c  = 1'b0;                                              // no carry at count 0
  if (op == shift_pkg::shl) begin
    res = (at << n) & m;
    if (n != 0) c = at[w - n];                            // last bit out the top
  end else begin
    res = at >> n;
    if (op == shift_pkg::sar && at[w - 1]) res = res | (m & ~(m >> n));  // sign fill
    if (n != 0) c = at[n - 1];                            // last bit out the bottom
  end
  if (cond_en && !cond_holds(flags_in, cond)) begin
    data  = at;                                           // suppressed op
    flags = flags_in;
  end else begin
    data  = res;
    flags = {c, 2'b00, res[w - 1], (res == '0), ~^res[7:0]};
  end
endfunction

task automatic check_data(string what, shift_pkg::data_t exp, shift_pkg::data_t act);
  if (act !== exp) begin
    $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
    errs_data++;
  end
endtask

task automatic check_flags(string what, shift_pkg::flags_t exp, shift_pkg::flags_t act);
  if (act !== exp) begin
    $display("Fail %s %s expected %b actual %b", cur_test, what, exp, act);
    errs_flags++;
  end
endtask

task automatic check_tag(string what, shift_pkg::tag_t exp, shift_pkg::tag_t act);
  if (act !== exp) begin
    $display("Fail %s %s expected %h actual %h", cur_test, what, exp, act);
    errs_tag++;
  end
endtask

task automatic check_count(string what, int exp, int act);
  if (act != exp) begin
    $display("Fail %s %s expected %0d actual %0d", cur_test, what, exp, act);
    errs_count++;
  end
endtask

`endif

/* testbench/tb_shift_unit.sv */
////////////////////////////////////////////////////////////////////////////
// shift cluster testbench
// directed tests through a credit-tracking issuer, a credit-granting
// consumer and an in-order result monitor
////////////////////////////////////////////////////////////////////////////

module tb_shift_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  localparam int N_OPS       = 308;                       // ops over all tests
  localparam int CYC_PER_OP  = 20;                        // incl. credit stalls
  localparam int LIMIT_NS    = (N_OPS * CYC_PER_OP + 100) * 8;

  typedef struct packed {
    shift_pkg::tag_t   tag;
    shift_pkg::data_t  data;
    shift_pkg::flags_t flags;
  } exp_t;

  logic                 clk;
  logic                 rst_n;
  logic                 in_valid;
  shift_pkg::shift_op_e in_op;
  shift_pkg::op_size_e  in_size;
  shift_pkg::data_t     in_a;
  shift_pkg::count_t    in_count;
  shift_pkg::tag_t      in_tag;
  logic                 in_cond_en;
  shift_pkg::cond_t     in_cond;
  shift_pkg::flags_t    in_flags;
  logic                 in_credit;
  logic                 res_valid;
  shift_pkg::tag_t      res_tag;
  shift_pkg::data_t     res_data;
  shift_pkg::flags_t    res_flags;
  logic                 out_credit;

  exp_t            exp_q[$];       // pending results in issue order
  exp_t            mon_e;
  string           cur_test;
  int              issue_credits;  // issuer's view of free queue slots
  int              owed;           // writeback credits still to hand back
  int              res_pulses;
  int              credit_pulses;
  int              errs_data;
  int              errs_flags;
  int              errs_tag;
  int              errs_count;
  int              errs_other;
  logic            credit_en;
  logic            credit_rand;    // return credits on random cycles
  logic [31:0]     stim_seed;
  logic [31:0]     credit_seed;
  logic [31:0]     credit_r;
  shift_pkg::tag_t next_tag;

  `include "tb_shift_model.svh"

  shift_unit #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  function automatic shift_pkg::data_t rand_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next(stim_seed);
    lo = lcg_next(stim_seed);
    return {hi, lo};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // watchdog, consumer and monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(LIMIT_NS);
    $display("Error: watchdog expired after %0d ns, results stopped arriving", LIMIT_NS);
    $display("Checks failed");
    $finish;
  end

  always @(posedge clk) begin
    #1;
    credit_r = lcg_next(credit_seed);
    if (credit_en && owed > 0 && (!credit_rand || credit_r[20])) begin
      out_credit = 1'b1;                                  // one credit per cycle
      owed--;
    end else begin
      out_credit = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (in_credit !== res_valid) begin
        $display("Error: in_credit and res_valid differ in %s", cur_test);
        errs_other++;
      end
      if (res_valid === 1'b1) begin
        res_pulses++;
        owed++;
        if (exp_q.size() == 0) begin
          $display("Error: result with tag %h arrived with nothing pending", res_tag);
          errs_other++;
        end else begin
          mon_e = exp_q.pop_front();
          check_tag("tag", mon_e.tag, res_tag);
          check_data("data", mon_e.data, res_data);
          check_flags("flags", mon_e.flags, res_flags);
        end
      end
      if (in_credit === 1'b1) begin
        credit_pulses++;
        issue_credits++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // issue side
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_op(shift_pkg::shift_op_e op, shift_pkg::op_size_e size,
                          shift_pkg::data_t a, shift_pkg::count_t count, logic cond_en,
                          shift_pkg::cond_t cond, shift_pkg::flags_t flags);
    exp_t              e;
    shift_pkg::data_t  d;
    shift_pkg::flags_t f;
    @(posedge clk);
    #1;
    while (issue_credits == 0) begin                      // stall until a slot frees
      in_valid = 1'b0;
      @(posedge clk);
      #1;
    end
    in_valid   = 1'b1;
    in_op      = op;
    in_size    = size;
    in_a       = a;
    in_count   = count;
    in_tag     = next_tag;
    in_cond_en = cond_en;
    in_cond    = cond;
    in_flags   = flags;
    model_op(op, size, a, count, cond_en, cond, flags, d, f);
    e.tag   = next_tag;
    e.data  = d;
    e.flags = f;
    exp_q.push_back(e);
    issue_credits--;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    go_idle();
    while (exp_q.size() != 0 || owed != 0) @(posedge clk);
    repeat (3) @(posedge clk);                            // last grant lands
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_logic_shifts();
    shift_pkg::count_t counts [6];
    shift_pkg::op_size_e size;
    counts   = '{6'd0, 6'd1, 6'd5, 6'd13, 6'd37, 6'd63};  // 0, in range, past width
    cur_test = "logic_shifts";
    for (int s = 0; s < 4; s++) begin
      size = shift_pkg::op_size_e'(2'(s));
      for (int k = 0; k < 6; k++) begin
        issue_op(shift_pkg::shl, size, rand_data(), counts[k], 1'b0, 4'd0,
                 6'(lcg_next(stim_seed)));
        issue_op(shift_pkg::shr, size, rand_data(), counts[k], 1'b0, 4'd0,
                 6'(lcg_next(stim_seed)));
      end
    end
    wait_drain();
  endtask

  task automatic test_sar();
    shift_pkg::count_t   counts [4];
    shift_pkg::data_t    a;
    shift_pkg::op_size_e size;
    counts   = '{6'd1, 6'd3, 6'd7, 6'd63};
    cur_test = "sar_sign_fill";
    for (int s = 0; s < 4; s++) begin
      size = shift_pkg::op_size_e'(2'(s));
      for (int k = 0; k < 4; k++) begin
        a = rand_data();
        a[(8 << s) - 1] = (k != 3);                       // negative except last
        issue_op(shift_pkg::sar, size, a, counts[k], 1'b0, 4'd0, 6'h3f);
      end
    end
    wait_drain();
  endtask

  task automatic test_flags();
    cur_test = "flag_forms";
    issue_op(shift_pkg::shl, shift_pkg::sz8, 64'hffff_ff80, 6'd1, 1'b0, 4'd0, 6'h3f); // zero
    issue_op(shift_pkg::shr, shift_pkg::sz16, 64'h8000, 6'd0, 1'b0, 4'd0, 6'h3f);      // sign
    issue_op(shift_pkg::shl, shift_pkg::sz64, 64'h3, 6'd0, 1'b0, 4'd0, 6'h3f);         // even
    issue_op(shift_pkg::shr, shift_pkg::sz32, 64'h7, 6'd0, 1'b0, 4'd0, 6'h3f);         // odd
    wait_drain();
  endtask

  task automatic test_cond();
    cur_test = "conditional";
    for (int c = 0; c < 16; c++) begin
      issue_op(shift_pkg::shl, shift_pkg::sz16, rand_data(), 6'd4, 1'b1, 4'(c), 6'h00);
      issue_op(shift_pkg::shl, shift_pkg::sz16, rand_data(), 6'd4, 1'b1, 4'(c), 6'h3f);
    end
    wait_drain();
  endtask

  task automatic test_backpressure();
    int res_start;
    cur_test  = "backpressure";
    credit_en = 1'b0;
    res_start = res_pulses;
    for (int i = 0; i < OUT_CREDITS + QUEUE_DEPTH; i++) begin
      issue_op(shift_pkg::shl, shift_pkg::sz32, rand_data(), 6'(lcg_next(stim_seed)),
               1'b0, 4'd0, 6'h00);
    end
    go_idle();
    repeat (12) @(posedge clk);                           // nothing may move now
    check_count("results while held", OUT_CREDITS, res_pulses - res_start);
    check_count("issue credits while held", 0, issue_credits);
    @(negedge clk);
    credit_en = 1'b1;
    for (int i = 0; i < 2; i++) begin
      issue_op(shift_pkg::shr, shift_pkg::sz8, rand_data(), 6'd3, 1'b0, 4'd0, 6'h00);
    end
    wait_drain();
    check_count("in_credit pulses", res_pulses, credit_pulses);
    check_count("issue credits after drain", QUEUE_DEPTH, issue_credits);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [1:0]  opb;
    cur_test    = "random";
    credit_rand = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r   = lcg_next(stim_seed);
      opb = 2'(r[31:16] % 16'd3);
      if (r[2]) go_idle();                                // occasional bubble
      issue_op(shift_pkg::shift_op_e'(opb), shift_pkg::op_size_e'(r[5:4]), rand_data(),
               r[13:8], r[3], r[27:24], r[21:16]);
    end
    wait_drain();
    credit_rand = 1'b0;
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_op         = shift_pkg::shl;
    in_size       = shift_pkg::sz8;
    in_a          = '0;
    in_count      = '0;
    in_tag        = '0;
    in_cond_en    = 1'b0;
    in_cond       = '0;
    in_flags      = '0;
    out_credit    = 1'b0;
    issue_credits = QUEUE_DEPTH;
    owed          = 0;
    res_pulses    = 0;
    credit_pulses = 0;
    errs_data     = 0;
    errs_flags    = 0;
    errs_tag      = 0;
    errs_count    = 0;
    errs_other    = 0;
    credit_en     = 1'b0;
    credit_rand   = 1'b0;
    stim_seed     = 32'ha71250de;
    credit_seed   = 32'ha71250de;
    next_tag      = '0;
    cur_test      = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (res_valid !== 1'b0 || in_credit !== 1'b0) begin
      $display("Error: res_valid or in_credit is set right after reset");
      errs_other++;
    end
    credit_en = 1'b1;
    test_logic_shifts();
    test_sar();
    test_flags();
    test_cond();
    test_backpressure();
    test_random();
    $display("error counts: data %0d, flags %0d, tag %0d, count %0d, other %0d",
             errs_data, errs_flags, errs_tag, errs_count, errs_other);
    if (errs_data + errs_flags + errs_tag + errs_count + errs_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
